// ==== jag_pkg.sv ====
// shared widths, download slots and address constants for the support logic
// slot compares look at the low index_slot_bits of ioctl_index only
// ddr addresses are 64-bit line addresses, byte lanes picked with ddram_be
`default_nettype none

package jag_pkg;

	// ========================================
	// widths
	// ========================================
	localparam int ioctl_addr_bits = 25;
	localparam int ddr_addr_bits   = 29;
	localparam int bios_addr_bits  = 17;   // 128 KiB boot rom
	localparam int bram_addr_bits  = 10;   // 1 K words of save ram
	localparam int index_slot_bits = 6;

	typedef logic [15:0]                ioctl_word_t;
	typedef logic [ioctl_addr_bits-1:0] ioctl_addr_t;   // byte address
	typedef logic [7:0]                 ioctl_index_t;
	typedef logic [ddr_addr_bits-1:0]   ddr_addr_t;
	typedef logic [63:0]                ddr_data_t;
	typedef logic [7:0]                 ddr_be_t;
	typedef logic [bios_addr_bits-1:0]  bios_addr_t;
	typedef logic [7:0]                 bios_byte_t;
	typedef logic [bram_addr_bits-1:0]  bram_addr_t;
	typedef logic [15:0]                bram_word_t;
	typedef logic [31:0]                sd_lba_t;
	typedef logic [7:0]                 sd_buff_addr_t;  // 256 words per sector

	// ========================================
	// download slots and addresses
	// ========================================
	localparam logic [index_slot_bits-1:0] index_cart   = 6'd1;
	localparam logic [index_slot_bits-1:0] index_bios_a = 6'd0;
	localparam logic [index_slot_bits-1:0] index_bios_b = 6'd2;

	localparam logic [31:0] cart_base  = 32'h0080_0000;  // where the core expects the cart
	localparam logic [7:0]  ddr_region = 8'h30;          // jaguar window in ddr

	// boot rom checksum branch, beq turned into bra
	localparam bios_addr_t patch_addr   = 17'h0136E;
	localparam bios_byte_t patch_opcode = 8'h60;

	localparam int unsigned backup_sectors = 4;  // 4 x 512 bytes = whole save ram

endpackage

`default_nettype wire

// ==== dual_port_ram.sv ====
// two-port synchronous ram, both ports read and write
// read data appears one cycle after the address, old data on read-during-write
// same-address writes from both ports in one cycle: port b wins
// no reset, contents undefined until written
`timescale 1ns/1ps
`default_nettype none

module dual_port_ram #(
	parameter type word_t    = logic [7:0],
	parameter int  addr_bits = 10
) (
	input  wire logic                 clk_sys,
	input  wire logic [addr_bits-1:0] addr_a,
	input  wire word_t                data_a,
	input  wire logic                 wr_a,
	output word_t                     q_a,
	input  wire logic [addr_bits-1:0] addr_b,
	input  wire word_t                data_b,
	input  wire logic                 wr_b,
	output word_t                     q_b
);

	word_t mem [0:(1 << addr_bits) - 1];

	always_ff @(posedge clk_sys) begin
		if (wr_a) mem[addr_a] <= data_a;
		if (wr_b) mem[addr_b] <= data_b;   // later write, takes priority
		q_a <= mem[addr_a];
		q_b <= mem[addr_b];
	end

endmodule

`default_nettype wire

// ==== cart_loader.sv ====
// cartridge download to ddr, one 64-bit line write per 16-bit ioctl word
// no back-pressure: ddr busy is ignored, host strobes at most every 3 cycles
// cart lands at cart_base inside the ddr_region window
// words are byte-swapped to the byte order the core reads back
`timescale 1ns/1ps
`default_nettype none

module cart_loader
	import jag_pkg::*;
(
	input  wire logic         clk_sys,
	input  wire logic         reset,
	input  wire logic         ioctl_download,
	input  wire ioctl_index_t ioctl_index,
	input  wire logic         ioctl_wr,
	input  wire ioctl_word_t  ioctl_data,
	output logic              loading,
	output ddr_addr_t         ddram_addr,
	output ddr_data_t         ddram_din,
	output ddr_be_t           ddram_be,
	output logic              ddram_we
);

	logic        cart_slot;
	logic        old_download;
	logic        wr_q;        // write cycle, one after the strobe
	logic [23:0] cart_addr;   // running byte address
	ioctl_word_t data_swap;

	assign cart_slot = ioctl_index[index_slot_bits-1:0] == index_cart;

	// ========================================
	// edge tracking and address counter
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			loading      <= 1'b0;
			wr_q         <= 1'b0;
			cart_addr    <= cart_base[23:0];
		end else begin
			old_download <= ioctl_download;
			wr_q         <= ioctl_wr & ioctl_download & cart_slot;

			if (wr_q) cart_addr <= cart_addr + 24'd2;   // 16-bit word per write

			// start of a cart download, rewind
			if (!old_download && ioctl_download && cart_slot) begin
				cart_addr <= cart_base[23:0];
				loading   <= 1'b1;
			end
			if (old_download && !ioctl_download) loading <= 1'b0;
		end
	end

	// payload, only meaningful with wr_q
	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) data_swap <= {ioctl_data[7:0], ioctl_data[15:8]};
	end

	// ========================================
	// ddr side
	// ========================================
	assign ddram_we   = wr_q;
	assign ddram_addr = {ddr_region, cart_addr[23:3]};   // line address
	assign ddram_din  = {4{data_swap}};                  // lane picked by be

	always_comb begin
		if (!loading) begin
			ddram_be = '1;   // idle, controller wants all lanes
		end else begin
			case (cart_addr[2:0])
				3'd0:    ddram_be = 8'b1100_0000;   // first word is the top lanes
				3'd2:    ddram_be = 8'b0011_0000;
				3'd4:    ddram_be = 8'b0000_1100;
				3'd6:    ddram_be = 8'b0000_0011;
				default: ddram_be = '1;             // odd address, never from host
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== bios_rom.sv ====
// boot rom in a 128 KiB byte ram, loaded from ioctl slot 0 or 2
// each word is written as two bytes, low byte at the even address first
// host strobes at most every 3 cycles, the writer needs two
// optional patch of the cart checksum branch on the read path
`timescale 1ns/1ps
`default_nettype none

module bios_rom
	import jag_pkg::*;
(
	input  wire logic         clk_sys,
	input  wire logic         reset,
	input  wire logic         ioctl_download,
	input  wire ioctl_index_t ioctl_index,
	input  wire logic         ioctl_wr,
	input  wire ioctl_addr_t  ioctl_addr,
	input  wire ioctl_word_t  ioctl_data,
	input  wire bios_addr_t   bios_addr,
	input  wire logic         checksum_patch,
	output bios_byte_t        bios_q
);

	logic                      bios_slot;
	logic                      wr_lo;   // even byte this cycle
	logic                      wr_hi;   // odd byte this cycle
	ioctl_word_t               word_q;
	logic [bios_addr_bits-2:0] word_addr;
	bios_addr_t                wr_addr;
	bios_byte_t                wr_byte;
	bios_byte_t                rd_byte;
	logic                      patch_hit;

	assign bios_slot = ioctl_index[index_slot_bits-1:0] == index_bios_a
		|| ioctl_index[index_slot_bits-1:0] == index_bios_b;

	// two-phase byte writer
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			wr_lo <= 1'b0;
			wr_hi <= 1'b0;
		end else begin
			wr_lo <= ioctl_wr & ioctl_download & bios_slot;
			wr_hi <= wr_lo;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (ioctl_wr) begin
			word_q    <= ioctl_data;
			word_addr <= ioctl_addr[bios_addr_bits-1:1];   // word index
		end
	end

	assign wr_addr = {word_addr, wr_hi};
	assign wr_byte = wr_hi ? word_q[15:8] : word_q[7:0];

	dual_port_ram #(
		.word_t    (bios_byte_t),
		.addr_bits (bios_addr_bits)
	) i_bios_ram (
		.clk_sys (clk_sys),
		.addr_a  (wr_addr),
		.data_a  (wr_byte),
		.wr_a    (wr_lo | wr_hi),
		.q_a     (),
		.addr_b  (bios_addr),
		.data_b  ('0),        // read-only port for the core
		.wr_b    (1'b0),
		.q_b     (rd_byte)
	);

	// compare lines up with the ram read latency
	always_ff @(posedge clk_sys) patch_hit <= bios_addr == patch_addr;

	assign bios_q = (patch_hit && checksum_patch) ? patch_opcode : rd_byte;

endmodule

`default_nettype wire

// ==== backup_sequencer.sv ====
// backup ram save/load over the sd block port, four sectors per transfer
// backup only enabled when a writable image is mounted during a cart download
// sd_rd/sd_wr drop on the ack rise, the next sector goes out on the ack fall
// load or save requests while busy are ignored
`timescale 1ns/1ps
`default_nettype none

module backup_sequencer
	import jag_pkg::*;
(
	input  wire logic clk_sys,
	input  wire logic reset,
	input  wire logic cart_download,
	input  wire logic img_mounted,
	input  wire logic img_readonly,
	input  wire logic osd_status,
	input  wire logic bram_wr,
	input  wire logic load_req,
	input  wire logic save_req,
	input  wire logic autosave,
	input  wire logic sd_ack,
	output sd_lba_t   sd_lba,
	output logic      sd_rd,
	output logic      sd_wr,
	output logic      busy,
	output logic      pending
);

	logic backup_enabled;
	logic save_cond;
	logic load_dir;        // 1 = sectors go sd -> ram
	logic old_download;
	logic old_load;
	logic old_save;
	logic old_ack;

	// explicit save, or autosave once the osd opens
	assign save_cond = save_req | (pending & osd_status & autosave);

	// ========================================
	// enable and pending
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			backup_enabled <= 1'b0;
			pending        <= 1'b0;
		end else begin
			if (!old_download && cart_download) backup_enabled <= 1'b0;   // new cart
			// save image is mounted before the download ends
			if (cart_download && img_mounted && !img_readonly) backup_enabled <= 1'b1;

			if (backup_enabled && !osd_status && bram_wr) pending <= 1'b1;
			else if (busy) pending <= 1'b0;
		end
	end

	// ========================================
	// sector state machine
	// ========================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			old_load     <= 1'b0;
			old_save     <= 1'b0;
			old_ack      <= 1'b0;
			busy         <= 1'b0;
			load_dir     <= 1'b0;
			sd_lba       <= '0;
			sd_rd        <= 1'b0;
			sd_wr        <= 1'b0;
		end else begin
			old_download <= cart_download;
			old_load     <= load_req;
			old_save     <= save_cond;
			old_ack      <= sd_ack;

			if (!old_ack && sd_ack) begin
				sd_rd <= 1'b0;   // host took the request
				sd_wr <= 1'b0;
			end

			if (!busy) begin
				if (backup_enabled && ((!old_load && load_req) || (!old_save && save_cond))) begin
					busy     <= 1'b1;
					load_dir <= load_req;
					sd_lba   <= '0;
					sd_rd    <= load_req;
					sd_wr    <= !load_req;
				end
				// cart just finished, pull the save in
				if (old_download && !cart_download && backup_enabled) begin
					busy     <= 1'b1;
					load_dir <= 1'b1;
					sd_lba   <= '0;
					sd_rd    <= 1'b1;
					sd_wr    <= 1'b0;
				end
			end else if (old_ack && !sd_ack) begin   // sector done
				if (sd_lba == sd_lba_t'(backup_sectors - 1)) begin
					busy   <= 1'b0;
					sd_lba <= '0;
				end else begin
					sd_lba <= sd_lba + 1'b1;
					sd_rd  <= load_dir;
					sd_wr  <= !load_dir;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== jag_support.sv ====
// support logic around the jaguar core, core ports brought out as loose ports
// cart to ddr, boot rom load and readback, backup ram with its sd sequencer
// sd side only reaches the backup ram for sectors 0..backup_sectors-1
`timescale 1ns/1ps
`default_nettype none

module jag_support
	import jag_pkg::*;
(
	input  wire logic          clk_sys,
	input  wire logic          reset,
	// download bus
	input  wire logic          ioctl_download,
	input  wire ioctl_index_t  ioctl_index,
	input  wire logic          ioctl_wr,
	input  wire ioctl_addr_t   ioctl_addr,
	input  wire ioctl_word_t   ioctl_data,
	// ddr write side
	output logic               loading,
	output ddr_addr_t          ddram_addr,
	output ddr_data_t          ddram_din,
	output ddr_be_t            ddram_be,
	output logic               ddram_we,
	// core boot rom
	input  wire bios_addr_t    bios_addr,
	input  wire logic          checksum_patch,
	output bios_byte_t         bios_q,
	// core backup ram
	input  wire bram_addr_t    bram_addr,
	input  wire bram_word_t    bram_data,
	input  wire logic          bram_wr,
	output bram_word_t         bram_q,
	// image and osd
	input  wire logic          img_mounted,
	input  wire logic          img_readonly,
	input  wire logic          osd_status,
	input  wire logic          load_req,
	input  wire logic          save_req,
	input  wire logic          autosave,
	// sd block port
	input  wire logic          sd_ack,
	output sd_lba_t            sd_lba,
	output logic               sd_rd,
	output logic               sd_wr,
	input  wire sd_buff_addr_t sd_buff_addr,
	input  wire bram_word_t    sd_buff_dout,
	input  wire logic          sd_buff_wr,
	output bram_word_t         sd_buff_din,
	output logic               busy,
	output logic               pending,
	output logic               led_user
);

	logic       cart_download;
	logic       sd_in_range;
	bram_addr_t sd_word_addr;

	assign cart_download = ioctl_download && ioctl_index[index_slot_bits-1:0] == index_cart;

	cart_loader i_cart_loader (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_data     (ioctl_data),
		.loading        (loading),
		.ddram_addr     (ddram_addr),
		.ddram_din      (ddram_din),
		.ddram_be       (ddram_be),
		.ddram_we       (ddram_we)
	);

	bios_rom i_bios_rom (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_data     (ioctl_data),
		.bios_addr      (bios_addr),
		.checksum_patch (checksum_patch),
		.bios_q         (bios_q)
	);

	// ========================================
	// backup ram, core on a, sd on b
	// ========================================
	assign sd_in_range  = sd_lba < backup_sectors;
	assign sd_word_addr = {sd_lba[1:0], sd_buff_addr};   // sector picks the quarter

	dual_port_ram #(
		.word_t    (bram_word_t),
		.addr_bits (bram_addr_bits)
	) i_backup_ram (
		.clk_sys (clk_sys),
		.addr_a  (bram_addr),
		.data_a  (bram_data),
		.wr_a    (bram_wr),
		.q_a     (bram_q),
		.addr_b  (sd_word_addr),
		.data_b  (sd_buff_dout),
		.wr_b    (sd_in_range & sd_buff_wr & sd_ack),
		.q_b     (sd_buff_din)
	);

	backup_sequencer i_backup_sequencer (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.osd_status    (osd_status),
		.bram_wr       (bram_wr),
		.load_req      (load_req),
		.save_req      (save_req),
		.autosave      (autosave),
		.sd_ack        (sd_ack),
		.sd_lba        (sd_lba),
		.sd_rd         (sd_rd),
		.sd_wr         (sd_wr),
		.busy          (busy),
		.pending       (pending)
	);

	assign led_user = loading | busy | pending;   // any activity lights it

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// testbench clock and reset source
// 8 ns clock, reset high for the first 3 rising edges
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic clk_sys,
	output logic reset
);

	initial begin
		clk_sys = 1'b0;
		reset   = 1'b1;
		repeat (3) @(posedge clk_sys);
		reset <= 1'b0;   // released on an edge, sync reset
	end

	always #4 clk_sys = ~clk_sys;   // 125 MHz

endmodule

`default_nettype wire

// ==== tb_jag_support.sv ====
// table-driven testbench for the jaguar support logic
// cart and boot rom steps come from a row table and backup steps are sequenced tasks
// sd host model answers a request after 4 cycles with a 256-word stream
// inputs change on the rising edge and outputs are sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_jag_support
	import jag_pkg::*;
();

	localparam int op_start  = 0;   // opens a download with the slot in addr
	localparam int op_end    = 1;
	localparam int op_cart   = 2;
	localparam int op_idle   = 3;   // ddram_be outside loading
	localparam int op_bwr    = 4;
	localparam int op_brd    = 5;   // data[0] = checksum_patch
	localparam int op_report = 6;
	localparam int num_transfers = 5;

	logic clk_sys, reset;
	logic ioctl_download, ioctl_wr, loading, ddram_we, checksum_patch;
	ioctl_index_t ioctl_index;
	ioctl_addr_t ioctl_addr;
	ioctl_word_t ioctl_data;
	ddr_addr_t ddram_addr;
	ddr_data_t ddram_din;
	ddr_be_t ddram_be;
	bios_addr_t bios_addr;
	bios_byte_t bios_q;
	bram_addr_t bram_addr;
	bram_word_t bram_data, bram_q, sd_buff_dout, sd_buff_din;
	logic bram_wr, img_mounted, img_readonly, osd_status, load_req, save_req, autosave;
	logic sd_ack, sd_rd, sd_wr, sd_buff_wr, busy, pending, led_user;
	sd_lba_t sd_lba;
	sd_buff_addr_t sd_buff_addr;

	int row_op[$];
	logic [31:0] row_addr[$];
	logic [15:0] row_data[$];
	logic [15:0] row_exp[$];
	bram_word_t bram_model [0:1023];   // expected backup ram contents
	logic [31:0] lfsr = 32'd90010;
	logic [23:0] cart_running;         // expected cart byte address
	int err_count = 0;
	int check_count = 0;
	int test_count = 0;
	int test_errs = 0;
	int cycles = 0;
	int limit = 1000000;

	tb_clock_gen i_clock_gen (.clk_sys(clk_sys), .reset(reset));

	jag_support i_jag_support (.*);

	// ========================================
	// helpers
	// ========================================
	function automatic logic [15:0] rand16();
		logic [15:0] w;
		logic nb;
		w = '0;
		for (int k = 0; k < 16; k++) begin
			nb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];   // taps 32,22,2,1
			lfsr = {lfsr[30:0], nb};
			w    = {w[14:0], nb};   // one bit per step
		end
		return w;
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		check_count++;
		if (exp !== act) begin
			err_count++;
			$display("Error: time %0t %s expected %h actual %h", $time, name, exp, act);
		end
	endtask

	task automatic end_test(input string name);
		test_count++;
		$display("test %0d %s: %s, %0d errors", test_count, name,
			(err_count == test_errs) ? "ok" : "bad", err_count - test_errs);
		test_errs = err_count;
	endtask

	task automatic add_row(input int op, input logic [31:0] a, input logic [15:0] d,
		input logic [15:0] e);
		row_op.push_back(op);
		row_addr.push_back(a);
		row_data.push_back(d);
		row_exp.push_back(e);
	endtask

	task automatic dl_start(input logic [7:0] idx);
		@(posedge clk_sys);
		ioctl_index    <= idx;
		ioctl_download <= 1'b1;
		repeat (2) @(posedge clk_sys);   // let loading settle
	endtask

	task automatic dl_end();
		@(posedge clk_sys);
		ioctl_download <= 1'b0;
		repeat (2) @(posedge clk_sys);
	endtask

	task automatic strobe(input logic [31:0] a, input logic [15:0] d);
		@(posedge clk_sys);
		ioctl_wr   <= 1'b1;
		ioctl_addr <= a[24:0];
		ioctl_data <= d;
		@(posedge clk_sys);
		ioctl_wr   <= 1'b0;
	endtask

	task automatic cart_write(input logic [15:0] d);
		logic [15:0] sw;
		sw = {d[7:0], d[15:8]};
		strobe({8'h0, cart_running}, d);
		@(negedge clk_sys);   // cycle N+1
		check("ddram_we", 1, ddram_we);
		check("loading", 1, loading);
		check("ddram_addr", {ddr_region, cart_running[23:3]}, ddram_addr);
		check("ddram_be", 8'hC0 >> (2 * cart_running[2:1]), ddram_be);
		check("ddram_din", {4{sw}}, ddram_din);
		cart_running = cart_running + 24'd2;
		@(negedge clk_sys);
		check("ddram_we", 0, ddram_we);   // single cycle only
	endtask

	task automatic bios_read(input logic [31:0] a, input logic p, input logic [15:0] e);
		@(posedge clk_sys);
		bios_addr      <= a[16:0];
		checksum_patch <= p;
		@(posedge clk_sys);
		@(negedge clk_sys);
		check("bios_q", e, bios_q);
	endtask

	task automatic pulse_load();
		@(posedge clk_sys);
		load_req <= 1'b1;
		@(posedge clk_sys);
		load_req <= 1'b0;
	endtask

	task automatic pulse_save();
		@(posedge clk_sys);
		save_req <= 1'b1;
		@(posedge clk_sys);
		save_req <= 1'b0;
	endtask

	task automatic expect_no_read(input int n);
		for (int k = 0; k < n; k++) begin
			@(negedge clk_sys);
			check("sd_rd", 0, sd_rd);
		end
	endtask

	// ========================================
	// sd host model
	// ========================================
	task automatic serve_sector(input logic is_load, input int lba);
		logic [15:0] d;
		while (!(sd_rd || sd_wr)) @(negedge clk_sys);
		check("sd_rd", is_load, sd_rd);
		check("sd_wr", !is_load, sd_wr);
		check("sd_lba", lba, sd_lba);
		repeat (4) @(posedge clk_sys);
		sd_ack <= 1'b1;
		for (int i = 0; i <= 256; i++) begin
			@(posedge clk_sys);
			if (i < 256) begin
				sd_buff_addr <= i[7:0];
				if (is_load) begin
					d = rand16();
					sd_buff_dout <= d;
					sd_buff_wr   <= 1'b1;
					bram_model[lba * 256 + i] = d;
				end
			end else begin
				sd_buff_wr <= 1'b0;
			end
			@(negedge clk_sys);
			if (i == 1) check("sd_rd|sd_wr after ack", 0, sd_rd | sd_wr);
			if (!is_load && i > 0) begin
				check("sd_buff_din", bram_model[lba * 256 + i - 1], sd_buff_din);
			end
		end
		@(posedge clk_sys);
		sd_ack <= 1'b0;
	endtask

	task automatic serve_transfer(input logic is_load);
		for (int s = 0; s < backup_sectors; s++) serve_sector(is_load, s);
		repeat (2) @(posedge clk_sys);
		@(negedge clk_sys);
		check("busy", 0, busy);
		check("sd_lba", 0, sd_lba);
	endtask

	task automatic bram_write_all();
		logic [15:0] d;
		for (int a = 0; a < 1024; a++) begin
			d = rand16();
			@(posedge clk_sys);
			bram_addr <= a[9:0];
			bram_data <= d;
			bram_wr   <= 1'b1;
			bram_model[a] = d;
		end
		@(posedge clk_sys);
		bram_wr <= 1'b0;
	endtask

	task automatic bram_check_all();
		for (int i = 0; i <= 1024; i++) begin
			@(posedge clk_sys);
			if (i < 1024) bram_addr <= i[9:0];
			@(negedge clk_sys);
			if (i > 0) check("bram_q", bram_model[i - 1], bram_q);   // one cycle behind
		end
	endtask

	// run limit
	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles > limit) begin
			$display("timeout: no finish within %0d cycles", limit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	// ========================================
	// main sequence
	// ========================================
	initial begin
		logic [15:0] w [0:4];
		logic [31:0] wa [0:4];
		ioctl_download = 0;
		ioctl_wr       = 0;
		ioctl_index    = '0;
		ioctl_addr     = '0;
		ioctl_data     = '0;
		bios_addr      = '0;
		checksum_patch = 0;
		bram_addr      = '0;
		bram_data      = '0;
		bram_wr        = 0;
		img_mounted    = 0;
		img_readonly   = 0;
		osd_status     = 0;
		load_req       = 0;
		save_req       = 0;
		autosave       = 0;
		sd_ack         = 0;
		sd_buff_addr   = '0;
		sd_buff_dout   = '0;
		sd_buff_wr     = 0;

		// cart rows
		add_row(op_idle, 0, 0, 16'hff);
		add_row(op_start, 1, 0, 0);
		for (int k = 0; k < 6; k++) add_row(op_cart, 0, rand16(), 0);
		add_row(op_end, 0, 0, 0);
		add_row(op_idle, 0, 0, 16'hff);
		add_row(op_report, 1, 0, 0);
		// bios rows with three words on slot 0 and two on slot 2
		wa[0] = 32'h0;
		wa[1] = 32'h2;
		wa[2] = 32'h136E;
		wa[3] = 32'h100;
		wa[4] = 32'h102;
		for (int k = 0; k < 5; k++) w[k] = rand16();
		add_row(op_start, 0, 0, 0);
		for (int k = 0; k < 3; k++) add_row(op_bwr, wa[k], w[k], 0);
		add_row(op_end, 0, 0, 0);
		add_row(op_start, 2, 0, 0);
		for (int k = 3; k < 5; k++) add_row(op_bwr, wa[k], w[k], 0);
		add_row(op_end, 0, 0, 0);
		for (int k = 0; k < 5; k++) begin
			add_row(op_brd, wa[k], 0, {8'h0, w[k][7:0]});        // even byte
			add_row(op_brd, wa[k] + 1, 0, {8'h0, w[k][15:8]});   // odd byte
		end
		add_row(op_brd, patch_addr, 1, patch_opcode);
		add_row(op_brd, patch_addr, 0, {8'h0, w[2][7:0]});
		add_row(op_brd, patch_addr + 1, 1, {8'h0, w[2][15:8]});   // neighbour stays unpatched
		add_row(op_report, 2, 0, 0);

		limit = row_op.size() * 8 + backup_sectors * 300 * num_transfers + 3 * 1100 + 2000;
		@(negedge reset);

		for (int i = 0; i < row_op.size(); i++) begin
			case (row_op[i])
				op_start: begin
					dl_start(row_addr[i][7:0]);
					cart_running = cart_base[23:0];
				end
				op_end:    dl_end();
				op_cart:   cart_write(row_data[i]);
				op_idle: begin
					@(negedge clk_sys);
					check("ddram_be", row_exp[i], ddram_be);
					check("loading", 0, loading);
				end
				op_bwr: begin
					strobe(row_addr[i], row_data[i]);
					@(posedge clk_sys);   // host gap, 3 cycles per strobe
				end
				op_brd:    bios_read(row_addr[i], row_data[i][0], row_exp[i]);
				op_report: begin
					if (row_addr[i] == 1) end_test("cartridge writes");
					else end_test("bios load and readback");
				end
				default: begin
					err_count++;
					$display("bad table op %0d in row %0d", row_op[i], i);
				end
			endcase
		end

		// enable with a writable image, then autoload, fill and save
		@(posedge clk_sys);
		img_mounted <= 1'b1;
		dl_start(8'd1);
		dl_end();
		serve_transfer(1'b1);
		bram_write_all();
		pulse_save();
		serve_transfer(1'b0);
		end_test("backup save");

		pulse_load();
		serve_transfer(1'b1);
		bram_check_all();
		end_test("backup load");

		// no image, then a read-only image
		@(posedge clk_sys);
		img_mounted <= 1'b0;
		dl_start(8'd1);
		dl_end();
		pulse_load();
		expect_no_read(20);
		@(posedge clk_sys);
		img_mounted  <= 1'b1;
		img_readonly <= 1'b1;
		dl_start(8'd1);
		dl_end();
		expect_no_read(20);
		pulse_load();
		expect_no_read(20);
		@(posedge clk_sys);
		img_readonly <= 1'b0;
		dl_start(8'd1);
		dl_end();
		serve_transfer(1'b1);
		check("pending", 0, pending);
		@(posedge clk_sys);
		bram_addr <= 10'd5;
		bram_data <= 16'h5a5a;
		bram_wr   <= 1'b1;
		bram_model[5] = 16'h5a5a;
		@(posedge clk_sys);
		bram_wr <= 1'b0;
		@(negedge clk_sys);
		check("pending", 1, pending);
		check("led_user", 1, led_user);
		@(posedge clk_sys);
		autosave   <= 1'b1;
		osd_status <= 1'b1;   // opening the osd starts the autosave
		serve_transfer(1'b0);
		check("pending", 0, pending);
		check("led_user", 0, led_user);
		@(posedge clk_sys);
		osd_status <= 1'b0;
		autosave   <= 1'b0;
		end_test("enable, pending and autosave");

		$display("tests %0d, checks %0d, errors %0d", test_count, check_count, err_count);
		if (err_count == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
jag_pkg.sv
dual_port_ram.sv
cart_loader.sv
bios_rom.sv
backup_sequencer.sv
jag_support.sv
tb_clock_gen.sv
tb_jag_support.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_jag_support
FILELIST  = files.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJDIR)
